/* compile.f */
hdl/wb_bus_pkg.sv
hdl/axi4_pkg.sv
hdl/wb2axi_ifs.sv
hdl/wb_port_arbiter.sv
hdl/wb2axi_req_channel.sv
hdl/wb2axi_res_channel.sv
hdl/wb2axi_bridge.sv
verification/axi_mem_model.sv
verification/wb2axi_bridge_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the bridge testbench with Verilator, then check the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f compile.f \
   --top-module wb2axi_bridge_tb -Mdir obj_dir -o wb2axi_bridge_sim > build.log 2>&1 \
   && ./obj_dir/wb2axi_bridge_sim > sim.log 2>&1 \
   || { echo "Build or simulation run failed, see build.log and sim.log"; exit 1; }

grep -q "^PASS: all tests$" sim.log \
   && echo "Simulation passed" \
   || { echo "Simulation failed, see sim.log"; exit 1; }

/* verification/wb2axi_bridge_tb.sv */
`timescale 1ns/10ps

module wb2axi_bridge_tb;

   // About 120 transfers at up to 30 cycles each, plus reset
   localparam int TIMEOUT_CYCLES = 4000;

   logic        clk_i = 1'b0;
   logic        rst_i;
   logic        wb0_cyc_i, wb0_stb_i, wb0_we_i, wb1_cyc_i, wb1_stb_i, wb1_we_i;
   logic [31:0] wb0_adr_i, wb1_adr_i;
   logic [63:0] wb0_dat_i, wb1_dat_i, wb_dat_o;
   logic [7:0]  wb0_sel_i, wb1_sel_i;
   logic        wb0_ack_o, wb0_err_o, wb1_ack_o, wb1_err_o;

   logic        axi_aw_valid_o, axi_aw_ready_i, axi_w_valid_o, axi_w_ready_i, axi_w_last_o;
   logic        axi_ar_valid_o, axi_ar_ready_i, axi_r_valid_i, axi_r_last_i, axi_r_ready_o;
   logic        axi_b_valid_i, axi_b_ready_o;
   logic [31:0] axi_aw_addr_o, axi_ar_addr_o;
   logic [2:0]  axi_aw_id_o, axi_ar_id_o, axi_r_id_i, axi_b_id_i;
   logic [7:0]  axi_aw_len_o, axi_ar_len_o, axi_w_strb_o;
   logic [2:0]  axi_aw_size_o, axi_ar_size_o;
   logic [1:0]  axi_aw_burst_o, axi_ar_burst_o, axi_r_resp_i, axi_b_resp_i;
   logic [5:0]  axi_aw_user_o, axi_w_user_o, axi_ar_user_o, axi_r_user_i, axi_b_user_i;
   logic [63:0] axi_w_data_o, axi_r_data_i;

   logic [63:0] shadow [256];
   int          errors = 0;
   int          cycles = 0;
   integer      seed = 32'h7c714d40;
   logic        compete = 1'b0;
   logic        have_last = 1'b0;
   logic        last_port, ack_port;
   logic [2:0]  served_id = '0;
   logic        aw_wait = 1'b0, w_wait = 1'b0, ar_wait = 1'b0;
   logic [31:0] aw_addr_q, ar_addr_q;
   logic [63:0] w_data_q;
   logic [7:0]  w_strb_q;

   always #4 clk_i = ~clk_i;

   wb2axi_bridge wb2axi_bridge_i (.*);

   axi_mem_model #(.ADDR_WIDTH(32), .DATA_WIDTH(64), .ID_WIDTH(3)) axi_mem_model_i (
      .clk_i      (clk_i),          .rst_i      (rst_i),
      .aw_valid_i (axi_aw_valid_o), .aw_addr_i  (axi_aw_addr_o), .aw_id_i (axi_aw_id_o),
      .aw_ready_o (axi_aw_ready_i), .w_valid_i  (axi_w_valid_o), .w_data_i (axi_w_data_o),
      .w_strb_i   (axi_w_strb_o),   .w_ready_o  (axi_w_ready_i), .b_valid_o (axi_b_valid_i),
      .b_resp_o   (axi_b_resp_i),   .b_id_o     (axi_b_id_i),    .ar_valid_i (axi_ar_valid_o),
      .ar_addr_i  (axi_ar_addr_o),  .ar_id_i    (axi_ar_id_o),   .ar_ready_o (axi_ar_ready_i),
      .r_valid_o  (axi_r_valid_i),  .r_data_o   (axi_r_data_i),  .r_resp_o (axi_r_resp_i),
      .r_last_o   (axi_r_last_i),   .r_id_o     (axi_r_id_i)
   );

   function automatic logic [63:0] fill_word(int unsigned i);
      return {32'(i) * 32'h9e3779b1, ~(32'(i) << 4)};
   endfunction

   function automatic logic [63:0] merge_bytes(logic [63:0] old_d, logic [63:0] new_d,
                                               logic [7:0] sel);
      logic [63:0] res;
      res = old_d;
      for (int b = 0; b < 8; b++) begin
         if (sel[b]) res[8*b +: 8] = new_d[8*b +: 8];
      end
      return res;
   endfunction

   task automatic report_mismatch(string name, logic [63:0] exp, logic [63:0] got);
      errors++;
      $display("** Error: %s expected %h got %h at %0t", name, exp, got, $time);
   endtask

   task automatic report_fault(string what);
      errors++;
      $display("** Error: %s at %0t", what, $time);
   endtask

   task automatic drive_port(int port, logic on, logic we, logic [31:0] adr,
                             logic [63:0] dat, logic [7:0] sel);
      if (port == 0) begin
         {wb0_cyc_i, wb0_stb_i, wb0_we_i} = {on, on, we};
         wb0_adr_i = adr;
         wb0_dat_i = dat;
         wb0_sel_i = sel;
      end else begin
         {wb1_cyc_i, wb1_stb_i, wb1_we_i} = {on, on, we};
         wb1_adr_i = adr;
         wb1_dat_i = dat;
         wb1_sel_i = sel;
      end
   endtask

   // One Wishbone classic cycle, held until ack or err
   task automatic wb_transfer(int port, logic we, logic [31:0] adr, logic [63:0] dat,
                              logic [7:0] sel, output logic [63:0] rdata,
                              output logic ack, output logic err);
      logic done;
      done = 1'b0;
      @(posedge clk_i);
      #1 drive_port(port, 1'b1, we, adr, dat, sel);
      while (!done) begin
         @(negedge clk_i);
         if (port == 0 ? (wb0_ack_o || wb0_err_o) : (wb1_ack_o || wb1_err_o)) begin
            done  = 1'b1;
            ack   = (port == 0) ? wb0_ack_o : wb1_ack_o;
            err   = (port == 0) ? wb0_err_o : wb1_err_o;
            rdata = wb_dat_o;
         end
      end
      @(posedge clk_i);
      #1 drive_port(port, 1'b0, 1'b0, '0, '0, '0);
   endtask

   // Transfer plus prediction from the shadow memory
   task automatic access(int port, logic we, logic [31:0] adr, logic [63:0] dat,
                         logic [7:0] sel);
      logic [63:0] rdata;
      logic        ack;
      logic        err;
      logic [7:0]  idx;
      idx = adr[10:3];
      wb_transfer(port, we, adr, dat, sel, rdata, ack, err);
      assert (err == adr[12] && ack == !adr[12])
         else report_fault($sformatf("port %0d wrong ack/err, adr %h", port, adr));
      if (!adr[12]) begin
         if (we) shadow[idx] = merge_bytes(shadow[idx], dat, sel);
         else assert (rdata == shadow[idx]) else report_mismatch("wb_dat_o", shadow[idx], rdata);
      end
   endtask

   initial begin
      wait (cycles >= TIMEOUT_CYCLES);
      $display("Timeout: transfers still pending after %0d cycles, %0d errors", cycles, errors);
      $display("FAIL: see errors above");
      $finish;
   end

   // **************************************************
   // Bus monitor, sampled at the falling edge
   // **************************************************
   always @(negedge clk_i) begin
      cycles++;
      assert (axi_r_ready_o && axi_b_ready_o) else report_fault("R or B ready is low");
      if (rst_i) begin
         assert (!axi_aw_valid_o && !axi_w_valid_o && !axi_ar_valid_o)
            else report_fault("AXI valid high during reset");
         assert (!wb0_ack_o && !wb0_err_o && !wb1_ack_o && !wb1_err_o)
            else report_fault("Wishbone ack or err high during reset");
      end else begin
         if (aw_wait) begin
            assert (axi_aw_valid_o) else report_fault("AW valid dropped before ready");
            assert (axi_aw_addr_o == aw_addr_q)
               else report_mismatch("axi_aw_addr_o", aw_addr_q, axi_aw_addr_o);
         end
         if (w_wait) begin
            assert (axi_w_valid_o) else report_fault("W valid dropped before ready");
            assert (axi_w_data_o == w_data_q)
               else report_mismatch("axi_w_data_o", w_data_q, axi_w_data_o);
            assert (axi_w_strb_o == w_strb_q)
               else report_mismatch("axi_w_strb_o", w_strb_q, axi_w_strb_o);
         end
         if (ar_wait) begin
            assert (axi_ar_valid_o) else report_fault("AR valid dropped before ready");
            assert (axi_ar_addr_o == ar_addr_q)
               else report_mismatch("axi_ar_addr_o", ar_addr_q, axi_ar_addr_o);
         end
         // A full 8-byte beat is AxSIZE 3
         if (axi_aw_valid_o) begin
            served_id = axi_aw_id_o;
            assert (axi_aw_len_o == 8'd0 && axi_aw_burst_o == 2'b01 && axi_w_last_o)
               else report_fault("Write is not a single INCR beat");
            assert (axi_aw_size_o == 3'd3)
               else report_mismatch("axi_aw_size_o", 64'(3'd3), 64'(axi_aw_size_o));
            assert (axi_aw_user_o == '0 && axi_w_user_o == '0)
               else report_fault("Write user bits are not zero");
         end
         if (axi_ar_valid_o) begin
            served_id = axi_ar_id_o;
            assert (axi_ar_len_o == 8'd0 && axi_ar_burst_o == 2'b01)
               else report_fault("Read is not a single INCR beat");
            assert (axi_ar_size_o == 3'd3)
               else report_mismatch("axi_ar_size_o", 64'(3'd3), 64'(axi_ar_size_o));
            assert (axi_ar_user_o == '0) else report_fault("Read user bits are not zero");
         end
         assert (!((wb0_ack_o || wb0_err_o) && (wb1_ack_o || wb1_err_o)))
            else report_fault("Both ports answered in the same cycle");
         assert (!((wb0_ack_o || wb0_err_o) && !wb0_stb_i)
                 && !((wb1_ack_o || wb1_err_o) && !wb1_stb_i))
            else report_fault("Answer on a port with no open cycle");
         if (wb0_ack_o || wb0_err_o || wb1_ack_o || wb1_err_o) begin
            ack_port = wb1_ack_o || wb1_err_o;
            assert (served_id == {2'b00, ack_port})
               else report_mismatch("axi id", 64'(ack_port), 64'(served_id));
            if (compete && have_last) begin
               assert (ack_port != last_port) else report_fault("Grant did not alternate");
            end
            last_port = ack_port;
            have_last = 1'b1;
         end
      end
      aw_wait   = axi_aw_valid_o && !axi_aw_ready_i;
      w_wait    = axi_w_valid_o && !axi_w_ready_i;
      ar_wait   = axi_ar_valid_o && !axi_ar_ready_i;
      aw_addr_q = axi_aw_addr_o;
      ar_addr_q = axi_ar_addr_o;
      w_data_q  = axi_w_data_o;
      w_strb_q  = axi_w_strb_o;
   end

   initial begin
      logic [31:0] r;
      rst_i        = 1'b1;
      axi_r_user_i = '0;
      axi_b_user_i = '0;
      drive_port(0, 1'b0, 1'b0, '0, '0, '0);
      drive_port(1, 1'b0, 1'b0, '0, '0, '0);
      for (int i = 0; i < 256; i++) shadow[i] = fill_word(i);
      repeat (8) @(posedge clk_i);
      #1 rst_i = 1'b0;

      // Full write then read back on port 0
      access(0, 1'b1, 32'h40, 64'h0123456789abcdef, 8'hff);
      access(0, 1'b0, 32'h40, '0, '0);

      // Partial byte lanes
      access(0, 1'b1, 32'h88, 64'h1111111111111111, 8'h0f);
      access(1, 1'b1, 32'h88, 64'h2222222222222222, 8'ha0);
      access(0, 1'b1, 32'h88, 64'h3333333333333333, 8'h01);
      access(1, 1'b0, 32'h88, '0, '0);

      // Both ports competing
      compete   = 1'b1;
      have_last = 1'b0;
      fork
         for (int k = 0; k < 6; k++) access(0, k[0], 32'h100 + 8 * k, 64'ha0a0 + k, 8'hff);
         for (int k = 0; k < 6; k++) access(1, !k[0], 32'h200 + 8 * k, 64'hb0b0 + k, 8'hff);
      join
      compete = 1'b0;

      // SLVERR region leaves memory alone
      access(0, 1'b1, 32'h1050, 64'hdeadbeefdeadbeef, 8'hff);
      access(1, 1'b0, 32'h1050, '0, '0);
      access(0, 1'b0, 32'h50, '0, '0);

      // Mixed random traffic under back-pressure
      repeat (100) begin
         r = $random(seed);
         access(int'(r[0]), r[1], {19'd0, r[15:13] == 3'd0, 1'b0, r[10:3], 3'd0},
                {$random(seed), $random(seed)}, r[16] ? 8'hff : r[31:24]);
      end

      repeat (4) @(posedge clk_i);
      $display("Checks finished with %0d errors", errors);
      if (errors == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

/* verification/axi_mem_model.sv */
`timescale 1ns/10ps

module axi_mem_model
   import axi4_pkg::*;
#(
   parameter int ADDR_WIDTH = 32,
   parameter int DATA_WIDTH = 64,
   parameter int ID_WIDTH   = 3,
   parameter int WORDS      = 256,
   parameter int ERR_BIT    = 12
) (
   input  logic                    clk_i,
   input  logic                    rst_i,
   input  logic                    aw_valid_i,
   input  logic [ADDR_WIDTH-1:0]   aw_addr_i,
   input  logic [ID_WIDTH-1:0]     aw_id_i,
   output logic                    aw_ready_o,
   input  logic                    w_valid_i,
   input  logic [DATA_WIDTH-1:0]   w_data_i,
   input  logic [DATA_WIDTH/8-1:0] w_strb_i,
   output logic                    w_ready_o,
   output logic                    b_valid_o,
   output logic [1:0]              b_resp_o,
   output logic [ID_WIDTH-1:0]     b_id_o,
   input  logic                    ar_valid_i,
   input  logic [ADDR_WIDTH-1:0]   ar_addr_i,
   input  logic [ID_WIDTH-1:0]     ar_id_i,
   output logic                    ar_ready_o,
   output logic                    r_valid_o,
   output logic [DATA_WIDTH-1:0]   r_data_o,
   output logic [1:0]              r_resp_o,
   output logic                    r_last_o,
   output logic [ID_WIDTH-1:0]     r_id_o
);

   localparam int LSB   = $clog2(DATA_WIDTH / 8);
   localparam int IDX_W = $clog2(WORDS);

   logic [DATA_WIDTH-1:0]   mem [WORDS];
   logic                    aw_got, w_got, ar_got;
   logic [ADDR_WIDTH-1:0]   aw_addr, ar_addr;
   logic [ID_WIDTH-1:0]     aw_id, ar_id;
   logic [DATA_WIDTH-1:0]   w_data;
   logic [DATA_WIDTH/8-1:0] w_strb;
   logic [IDX_W-1:0]        idx;
   logic [31:0]             rnd;
   integer                  seed = 32'h7c714d40;

   initial begin
      for (int i = 0; i < WORDS; i++) begin
         mem[i] = DATA_WIDTH'({32'(i) * 32'h9e3779b1, ~(32'(i) << 4)});
      end
      {aw_got, w_got, ar_got} = '0;
      {aw_ready_o, w_ready_o, ar_ready_o, b_valid_o, r_valid_o, r_last_o} = '0;
      b_resp_o = '0;
      b_id_o   = '0;
      r_resp_o = '0;
      r_id_o   = '0;
      r_data_o = '0;
   end

   // Handshakes are taken at the edge, outputs change 1 ns later
   always @(posedge clk_i) begin
      if (aw_valid_i && aw_ready_o) begin
         aw_got  = 1'b1;
         aw_addr = aw_addr_i;
         aw_id   = aw_id_i;
      end
      if (w_valid_i && w_ready_o) begin
         w_got  = 1'b1;
         w_data = w_data_i;
         w_strb = w_strb_i;
      end
      if (ar_valid_i && ar_ready_o) begin
         ar_got  = 1'b1;
         ar_addr = ar_addr_i;
         ar_id   = ar_id_i;
      end
      #1;
      b_valid_o = 1'b0;
      r_valid_o = 1'b0;
      r_last_o  = 1'b0;
      if (rst_i) begin
         {aw_got, w_got, ar_got} = '0;
      end else begin
         if (aw_got && w_got) begin
            idx = aw_addr[LSB +: IDX_W];
            if (!aw_addr[ERR_BIT]) begin
               for (int b = 0; b < DATA_WIDTH / 8; b++) begin
                  if (w_strb[b]) mem[idx][8*b +: 8] = w_data[8*b +: 8];
               end
            end
            b_resp_o  = aw_addr[ERR_BIT] ? AXI_RESP_SLVERR : AXI_RESP_OKAY;
            b_id_o    = aw_id;
            b_valid_o = 1'b1;
            aw_got    = 1'b0;
            w_got     = 1'b0;
         end
         if (ar_got) begin
            idx       = ar_addr[LSB +: IDX_W];
            r_data_o  = ar_addr[ERR_BIT] ? '0 : mem[idx];
            r_resp_o  = ar_addr[ERR_BIT] ? AXI_RESP_SLVERR : AXI_RESP_OKAY;
            r_id_o    = ar_id;
            r_valid_o = 1'b1;
            r_last_o  = 1'b1;
            ar_got    = 1'b0;
         end
      end
      // Random back-pressure on the request channels
      rnd        = $random(seed);
      aw_ready_o = rnd[0];
      w_ready_o  = rnd[1];
      ar_ready_o = rnd[2];
   end

endmodule

/* hdl/wb2axi_bridge.sv */
`timescale 1ns/10ps

module wb2axi_bridge
   import wb_bus_pkg::*;
#(
   parameter int WB_ADDR_WIDTH  = 32,
   parameter int WB_DATA_WIDTH  = 64,
   parameter int AXI_ID_WIDTH   = 3,
   parameter int AXI_USER_WIDTH = 6
) (
   input  logic                       clk_i,
   input  logic                       rst_i,

   // **************************************************
   // Wishbone slave port 0
   input  logic                       wb0_cyc_i,
   input  logic                       wb0_stb_i,
   input  logic                       wb0_we_i,
   input  logic [WB_ADDR_WIDTH-1:0]   wb0_adr_i,
   input  logic [WB_DATA_WIDTH-1:0]   wb0_dat_i,
   input  logic [WB_DATA_WIDTH/8-1:0] wb0_sel_i,
   output logic                       wb0_ack_o,
   output logic                       wb0_err_o,

   // Wishbone slave port 1
   input  logic                       wb1_cyc_i,
   input  logic                       wb1_stb_i,
   input  logic                       wb1_we_i,
   input  logic [WB_ADDR_WIDTH-1:0]   wb1_adr_i,
   input  logic [WB_DATA_WIDTH-1:0]   wb1_dat_i,
   input  logic [WB_DATA_WIDTH/8-1:0] wb1_sel_i,
   output logic                       wb1_ack_o,
   output logic                       wb1_err_o,

   // Read data shared by both ports
   output logic [WB_DATA_WIDTH-1:0]   wb_dat_o,

   // **************************************************
   // AXI4 master
   output logic                       axi_aw_valid_o,
   output logic [WB_ADDR_WIDTH-1:0]   axi_aw_addr_o,
   output logic [AXI_ID_WIDTH-1:0]    axi_aw_id_o,
   output logic [7:0]                 axi_aw_len_o,
   output logic [2:0]                 axi_aw_size_o,
   output logic [1:0]                 axi_aw_burst_o,
   output logic [AXI_USER_WIDTH-1:0]  axi_aw_user_o,
   input  logic                       axi_aw_ready_i,
   output logic                       axi_w_valid_o,
   output logic [WB_DATA_WIDTH-1:0]   axi_w_data_o,
   output logic [WB_DATA_WIDTH/8-1:0] axi_w_strb_o,
   output logic                       axi_w_last_o,
   output logic [AXI_USER_WIDTH-1:0]  axi_w_user_o,
   input  logic                       axi_w_ready_i,
   output logic                       axi_ar_valid_o,
   output logic [WB_ADDR_WIDTH-1:0]   axi_ar_addr_o,
   output logic [AXI_ID_WIDTH-1:0]    axi_ar_id_o,
   output logic [7:0]                 axi_ar_len_o,
   output logic [2:0]                 axi_ar_size_o,
   output logic [1:0]                 axi_ar_burst_o,
   output logic [AXI_USER_WIDTH-1:0]  axi_ar_user_o,
   input  logic                       axi_ar_ready_i,
   input  logic                       axi_r_valid_i,
   input  logic [WB_DATA_WIDTH-1:0]   axi_r_data_i,
   input  logic [1:0]                 axi_r_resp_i,
   input  logic                       axi_r_last_i,
   input  logic [AXI_ID_WIDTH-1:0]    axi_r_id_i,
   input  logic [AXI_USER_WIDTH-1:0]  axi_r_user_i,
   output logic                       axi_r_ready_o,
   input  logic                       axi_b_valid_i,
   input  logic [1:0]                 axi_b_resp_i,
   input  logic [AXI_ID_WIDTH-1:0]    axi_b_id_i,
   input  logic [AXI_USER_WIDTH-1:0]  axi_b_user_i,
   output logic                       axi_b_ready_o
);

   logic                       wb_cyc [NUM_PORTS];
   logic                       wb_stb [NUM_PORTS];
   logic                       wb_we  [NUM_PORTS];
   logic [WB_ADDR_WIDTH-1:0]   wb_adr [NUM_PORTS];
   logic [WB_DATA_WIDTH-1:0]   wb_dat [NUM_PORTS];
   logic [WB_DATA_WIDTH/8-1:0] wb_sel [NUM_PORTS];

   // Gather the two slave ports into arrays indexed by port
   assign wb_cyc[0] = wb0_cyc_i;
   assign wb_cyc[1] = wb1_cyc_i;
   assign wb_stb[0] = wb0_stb_i;
   assign wb_stb[1] = wb1_stb_i;
   assign wb_we[0]  = wb0_we_i;
   assign wb_we[1]  = wb1_we_i;
   assign wb_adr[0] = wb0_adr_i;
   assign wb_adr[1] = wb1_adr_i;
   assign wb_dat[0] = wb0_dat_i;
   assign wb_dat[1] = wb1_dat_i;
   assign wb_sel[0] = wb0_sel_i;
   assign wb_sel[1] = wb1_sel_i;

   wb_req_if #(
      .WB_ADDR_WIDTH (WB_ADDR_WIDTH),
      .WB_DATA_WIDTH (WB_DATA_WIDTH)
   ) req_if ();

   wb_res_if #(
      .WB_DATA_WIDTH (WB_DATA_WIDTH)
   ) res_if ();

   wb_port_arbiter #(
      .WB_ADDR_WIDTH (WB_ADDR_WIDTH),
      .WB_DATA_WIDTH (WB_DATA_WIDTH)
   ) wb_port_arbiter_i (
      .clk_i    (clk_i),
      .rst_i    (rst_i),
      .wb_cyc_i (wb_cyc),
      .wb_stb_i (wb_stb),
      .wb_we_i  (wb_we),
      .wb_adr_i (wb_adr),
      .wb_dat_i (wb_dat),
      .wb_sel_i (wb_sel),
      .req      (req_if),
      .res      (res_if)
   );

   wb2axi_req_channel #(
      .WB_ADDR_WIDTH  (WB_ADDR_WIDTH),
      .WB_DATA_WIDTH  (WB_DATA_WIDTH),
      .AXI_ID_WIDTH   (AXI_ID_WIDTH),
      .AXI_USER_WIDTH (AXI_USER_WIDTH)
   ) wb2axi_req_channel_i (
      .clk_i          (clk_i),
      .rst_i          (rst_i),
      .req            (req_if),
      .axi_aw_valid_o (axi_aw_valid_o),
      .axi_aw_addr_o  (axi_aw_addr_o),
      .axi_aw_id_o    (axi_aw_id_o),
      .axi_aw_len_o   (axi_aw_len_o),
      .axi_aw_size_o  (axi_aw_size_o),
      .axi_aw_burst_o (axi_aw_burst_o),
      .axi_aw_user_o  (axi_aw_user_o),
      .axi_aw_ready_i (axi_aw_ready_i),
      .axi_w_valid_o  (axi_w_valid_o),
      .axi_w_data_o   (axi_w_data_o),
      .axi_w_strb_o   (axi_w_strb_o),
      .axi_w_last_o   (axi_w_last_o),
      .axi_w_user_o   (axi_w_user_o),
      .axi_w_ready_i  (axi_w_ready_i),
      .axi_ar_valid_o (axi_ar_valid_o),
      .axi_ar_addr_o  (axi_ar_addr_o),
      .axi_ar_id_o    (axi_ar_id_o),
      .axi_ar_len_o   (axi_ar_len_o),
      .axi_ar_size_o  (axi_ar_size_o),
      .axi_ar_burst_o (axi_ar_burst_o),
      .axi_ar_user_o  (axi_ar_user_o),
      .axi_ar_ready_i (axi_ar_ready_i)
   );

   wb2axi_res_channel #(
      .WB_DATA_WIDTH  (WB_DATA_WIDTH),
      .AXI_ID_WIDTH   (AXI_ID_WIDTH),
      .AXI_USER_WIDTH (AXI_USER_WIDTH)
   ) wb2axi_res_channel_i (
      .axi_r_valid_i (axi_r_valid_i),
      .axi_r_data_i  (axi_r_data_i),
      .axi_r_resp_i  (axi_r_resp_i),
      .axi_r_last_i  (axi_r_last_i),
      .axi_r_id_i    (axi_r_id_i),
      .axi_r_user_i  (axi_r_user_i),
      .axi_r_ready_o (axi_r_ready_o),
      .axi_b_valid_i (axi_b_valid_i),
      .axi_b_resp_i  (axi_b_resp_i),
      .axi_b_id_i    (axi_b_id_i),
      .axi_b_user_i  (axi_b_user_i),
      .axi_b_ready_o (axi_b_ready_o),
      .res           (res_if)
   );

   // Per-port strobes, data qualified by each port's own ack
   assign wb0_ack_o = res_if.ack[0];
   assign wb0_err_o = res_if.err[0];
   assign wb1_ack_o = res_if.ack[1];
   assign wb1_err_o = res_if.err[1];
   assign wb_dat_o  = res_if.dat;

endmodule

/* hdl/wb2axi_res_channel.sv */
`timescale 1ns/10ps

module wb2axi_res_channel
   import wb_bus_pkg::*;
   import axi4_pkg::*;
#(
   parameter int WB_DATA_WIDTH  = 64,
   parameter int AXI_ID_WIDTH   = 3,
   parameter int AXI_USER_WIDTH = 6
) (
   // AXI4 read data channel
   input  logic                      axi_r_valid_i,
   input  logic [WB_DATA_WIDTH-1:0]  axi_r_data_i,
   input  logic [1:0]                axi_r_resp_i,
   input  logic                      axi_r_last_i,
   input  logic [AXI_ID_WIDTH-1:0]   axi_r_id_i,
   input  logic [AXI_USER_WIDTH-1:0] axi_r_user_i,
   output logic                      axi_r_ready_o,

   // AXI4 write response channel
   input  logic                      axi_b_valid_i,
   input  logic [1:0]                axi_b_resp_i,
   input  logic [AXI_ID_WIDTH-1:0]   axi_b_id_i,
   input  logic [AXI_USER_WIDTH-1:0] axi_b_user_i,
   output logic                      axi_b_ready_o,

   wb_res_if.source                  res
);

   logic      r_end;
   logic      b_end;
   axi_resp_e resp;
   port_idx_t port;

   // Always ready, one transaction in flight at most
   assign axi_r_ready_o = 1'b1;
   assign axi_b_ready_o = 1'b1;

   assign r_end = axi_r_ready_o && axi_r_valid_i && axi_r_last_i;
   assign b_end = axi_b_ready_o && axi_b_valid_i;

   // R and B never overlap, so pick whichever is active
   assign resp = r_end ? axi_resp_e'(axi_r_resp_i) : axi_resp_e'(axi_b_resp_i);
   assign port = r_end ? port_idx_t'(axi_r_id_i) : port_idx_t'(axi_b_id_i);

   always_comb begin
      res.ack = '0;
      res.err = '0;
      if (r_end || b_end) begin
         if (resp == AXI_RESP_OKAY || resp == AXI_RESP_EXOKAY) res.ack[port] = 1'b1;
         else res.err[port] = 1'b1;
      end
   end

   assign res.dat  = axi_r_data_i;
   assign res.done = r_end || b_end;

endmodule

/* hdl/wb2axi_req_channel.sv */
`timescale 1ns/10ps

module wb2axi_req_channel
   import wb_bus_pkg::*;
   import axi4_pkg::*;
#(
   parameter int WB_ADDR_WIDTH  = 32,
   parameter int WB_DATA_WIDTH  = 64,
   parameter int AXI_ID_WIDTH   = 3,
   parameter int AXI_USER_WIDTH = 6
) (
   input  logic                       clk_i,
   input  logic                       rst_i,

   wb_req_if.channel                  req,

   // **************************************************
   // AXI4 write address channel
   output logic                       axi_aw_valid_o,
   output logic [WB_ADDR_WIDTH-1:0]   axi_aw_addr_o,
   output logic [AXI_ID_WIDTH-1:0]    axi_aw_id_o,
   output logic [7:0]                 axi_aw_len_o,
   output logic [2:0]                 axi_aw_size_o,
   output logic [1:0]                 axi_aw_burst_o,
   output logic [AXI_USER_WIDTH-1:0]  axi_aw_user_o,
   input  logic                       axi_aw_ready_i,

   // AXI4 write data channel
   output logic                       axi_w_valid_o,
   output logic [WB_DATA_WIDTH-1:0]   axi_w_data_o,
   output logic [WB_DATA_WIDTH/8-1:0] axi_w_strb_o,
   output logic                       axi_w_last_o,
   output logic [AXI_USER_WIDTH-1:0]  axi_w_user_o,
   input  logic                       axi_w_ready_i,

   // AXI4 read address channel
   output logic                       axi_ar_valid_o,
   output logic [WB_ADDR_WIDTH-1:0]   axi_ar_addr_o,
   output logic [AXI_ID_WIDTH-1:0]    axi_ar_id_o,
   output logic [7:0]                 axi_ar_len_o,
   output logic [2:0]                 axi_ar_size_o,
   output logic [1:0]                 axi_ar_burst_o,
   output logic [AXI_USER_WIDTH-1:0]  axi_ar_user_o,
   input  logic                       axi_ar_ready_i
);

   // Every beat spans the full data bus
   localparam logic [2:0] BEAT_SIZE = axi_size_for_bytes(WB_DATA_WIDTH / 8);

   logic                       aw_valid_q;
   logic                       w_valid_q;
   logic                       ar_valid_q;
   logic [WB_ADDR_WIDTH-1:0]   addr_q;
   logic [WB_DATA_WIDTH-1:0]   data_q;
   logic [WB_DATA_WIDTH/8-1:0] strb_q;
   port_idx_t                  port_q;

   // Valids rise the cycle after launch, each falls after its own handshake
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         aw_valid_q <= 1'b0;
         w_valid_q  <= 1'b0;
         ar_valid_q <= 1'b0;
      end else if (req.launch) begin
         aw_valid_q <= req.we;
         w_valid_q  <= req.we;
         ar_valid_q <= !req.we;
      end else begin
         if (axi_aw_ready_i) aw_valid_q <= 1'b0;
         if (axi_w_ready_i)  w_valid_q  <= 1'b0;
         if (axi_ar_ready_i) ar_valid_q <= 1'b0;
      end
   end

   // Held stable until the next launch
   always_ff @(posedge clk_i) begin
      if (req.launch) begin
         addr_q <= req.adr;
         data_q <= req.dat;
         strb_q <= req.sel;
         port_q <= req.port;
      end
   end

   assign axi_aw_valid_o = aw_valid_q;
   assign axi_aw_addr_o  = addr_q;
   assign axi_aw_id_o    = AXI_ID_WIDTH'(port_q);
   assign axi_aw_len_o   = AXI_LEN_SINGLE;
   assign axi_aw_size_o  = BEAT_SIZE;
   assign axi_aw_burst_o = AXI_BURST_INCR;
   assign axi_aw_user_o  = '0;

   assign axi_w_valid_o  = w_valid_q;
   assign axi_w_data_o   = data_q;
   assign axi_w_strb_o   = strb_q;
   assign axi_w_last_o   = 1'b1;
   assign axi_w_user_o   = '0;

   assign axi_ar_valid_o = ar_valid_q;
   assign axi_ar_addr_o  = addr_q;
   assign axi_ar_id_o    = AXI_ID_WIDTH'(port_q);
   assign axi_ar_len_o   = AXI_LEN_SINGLE;
   assign axi_ar_size_o  = BEAT_SIZE;
   assign axi_ar_burst_o = AXI_BURST_INCR;
   assign axi_ar_user_o  = '0;

endmodule

/* hdl/wb_port_arbiter.sv */
`timescale 1ns/10ps

module wb_port_arbiter
   import wb_bus_pkg::*;
#(
   parameter int WB_ADDR_WIDTH = 32,
   parameter int WB_DATA_WIDTH = 64
) (
   input  logic                       clk_i,
   input  logic                       rst_i,

   // Wishbone classic slave ports
   input  logic                       wb_cyc_i [NUM_PORTS],
   input  logic                       wb_stb_i [NUM_PORTS],
   input  logic                       wb_we_i  [NUM_PORTS],
   input  logic [WB_ADDR_WIDTH-1:0]   wb_adr_i [NUM_PORTS],
   input  logic [WB_DATA_WIDTH-1:0]   wb_dat_i [NUM_PORTS],
   input  logic [WB_DATA_WIDTH/8-1:0] wb_sel_i [NUM_PORTS],

   wb_req_if.arbiter                  req,
   wb_res_if.monitor                  res
);

   logic [NUM_PORTS-1:0] port_req;
   logic                 busy_q;
   port_idx_t            grant_q;
   logic                 pick_valid;
   port_idx_t            pick;

   always_comb begin : port_request
      for (int p = 0; p < NUM_PORTS; p++) begin
         port_req[p] = wb_cyc_i[p] && wb_stb_i[p];
      end
   end

   // **************************************************
   // Round robin, starting after the last granted port
   // **************************************************
   always_comb begin : round_robin
      port_idx_t cand;
      pick_valid = 1'b0;
      pick       = grant_q;
      for (int unsigned k = 1; k <= NUM_PORTS; k++) begin
         cand = port_after(grant_q, k);
         if (!pick_valid && port_req[cand]) begin
            pick_valid = 1'b1;
            pick       = cand;
         end
      end
   end

   // Busy from launch until the response channel reports done
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         busy_q     <= 1'b0;
         grant_q    <= '0;
         req.launch <= 1'b0;
      end else begin
         req.launch <= 1'b0;
         if (!busy_q) begin
            if (pick_valid) begin
               busy_q     <= 1'b1;
               grant_q    <= pick;
               req.launch <= 1'b1;
            end
         end else if (res.done) begin
            busy_q <= 1'b0;
         end
      end
   end

   // Capture the winning request
   always_ff @(posedge clk_i) begin
      if (!busy_q && pick_valid) begin
         req.we  <= wb_we_i[pick];
         req.adr <= wb_adr_i[pick];
         req.dat <= wb_dat_i[pick];
         req.sel <= wb_sel_i[pick];
      end
   end

   // Grant register doubles as the pointer for the next round
   assign req.port = grant_q;

endmodule

/* hdl/wb2axi_ifs.sv */
`timescale 1ns/10ps

// Request handed from the arbiter to the AXI request channel
interface wb_req_if
   import wb_bus_pkg::*;
#(
   parameter int WB_ADDR_WIDTH = 32,
   parameter int WB_DATA_WIDTH = 64
);

   // Payload is only meaningful while launch is high
   logic                       launch;
   logic                       we;
   logic [WB_ADDR_WIDTH-1:0]   adr;
   logic [WB_DATA_WIDTH-1:0]   dat;
   logic [WB_DATA_WIDTH/8-1:0] sel;
   port_idx_t                  port;

   modport arbiter (output launch, output we, output adr, output dat, output sel,
                    output port);

   modport channel (input launch, input we, input adr, input dat, input sel,
                    input port);

endinterface

// Responses routed back to the Wishbone ports
interface wb_res_if
   import wb_bus_pkg::*;
#(
   parameter int WB_DATA_WIDTH = 64
);

   // One strobe per port, indexed by port_idx_t
   logic [NUM_PORTS-1:0]     ack;
   logic [NUM_PORTS-1:0]     err;
   logic [WB_DATA_WIDTH-1:0] dat;
   logic                     done;

   modport source (output ack, output err, output dat, output done);

   modport monitor (input done);

   modport port (input ack, input err, input dat);

endinterface

/* hdl/axi4_pkg.sv */
package axi4_pkg;

   // Response codes on R and B
   typedef enum logic [1:0] {
      AXI_RESP_OKAY   = 2'b00,
      AXI_RESP_EXOKAY = 2'b01,
      AXI_RESP_SLVERR = 2'b10,
      AXI_RESP_DECERR = 2'b11
   } axi_resp_e;

   localparam logic [1:0] AXI_BURST_INCR = 2'b01;

   // AxLEN for a single beat
   localparam logic [7:0] AXI_LEN_SINGLE = 8'd0;

   // AxSIZE encoding for a beat of the given byte count
   function automatic logic [2:0] axi_size_for_bytes(int unsigned bytes);
      case (bytes)
         1:       return 3'd0;
         2:       return 3'd1;
         4:       return 3'd2;
         8:       return 3'd3;
         16:      return 3'd4;
         32:      return 3'd5;
         64:      return 3'd6;
         128:     return 3'd7;
         default: return 3'd0;
      endcase
   endfunction

endpackage

/* hdl/wb_bus_pkg.sv */
package wb_bus_pkg;

   // Number of Wishbone slave ports sharing the AXI master
   localparam int unsigned NUM_PORTS = 2;

   // Port index, also used as the AXI ID value
   typedef logic [$clog2(NUM_PORTS)-1:0] port_idx_t;

   // Port reached by stepping forward from base, wrapping around
   function automatic port_idx_t port_after(port_idx_t base, int unsigned offset);
      int unsigned idx;
      idx = base;
      idx = (idx + offset) % NUM_PORTS;
      return port_idx_t'(idx);
   endfunction

endpackage
